/* sim.f */
rv_isa_pkg.sv
core_pkg.sv
instr_mem.sv
decoder.sv
regfile.sv
alu.sv
data_mem.sv
hazard_unit.sv
retire_sender.sv
pipeline_core.sv
tb_pipeline.sv

/* tb_pipeline.sv */
`timescale 1ns/1ns
module tb_pipeline;

    localparam int RETIRE_CREDITS = 4;
    localparam int NUM_TESTS      = 6;
    localparam int PROG_WORDS     = 8;
    localparam int WAIT_LIMIT     = 400;   // cycles allowed per test

    logic              clk;
    logic              reset;
    logic              prog_we;
    logic [31:0]       prog_addr;
    logic [31:0]       prog_data;
    core_pkg::retire_t retire;
    logic              retire_valid;
    logic              retire_credit;

    logic [31:0]       prog_tab  [NUM_TESTS][PROG_WORDS];
    core_pkg::retire_t exp_tab   [NUM_TESTS][PROG_WORDS];
    int                exp_cnt   [NUM_TESTS];
    string             test_name [NUM_TESTS];

    int errors, checks, failed_tests, tests_run, err_before;
    int seed;
    bit timed_out;

    pipeline_core #(.RETIRE_CREDITS(RETIRE_CREDITS)) u_pipeline_core (
        .clk, .reset, .prog_we, .prog_addr, .prog_data,
        .retire, .retire_valid, .retire_credit
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // instruction encoders
    function automatic logic [31:0] alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] ld(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b011, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sd(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                           input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // program word plus the record it must retire, pc is 4 * i
    task automatic add_step(input int t, input int i, input logic [31:0] w, input logic we,
                            input logic [4:0] rd, input logic [63:0] wdata);
        prog_tab[t][i] = w;
        exp_tab[t][exp_cnt[t]] = '{pc: 64'(4 * i), instr: w, rd: rd, reg_we: we, wdata: wdata};
        exp_cnt[t]++;
    endtask

    task automatic fill_tables();
        logic [31:0] nop;
        nop = addi(5'd0, 5'd0, 12'd0);
        for (int t = 0; t < NUM_TESTS; t++) begin
            exp_cnt[t] = 0;
            for (int i = 0; i < PROG_WORDS; i++) begin
                prog_tab[t][i] = nop;
            end
        end
        test_name = '{"independent alu", "forwarding", "store load use", "branch and jal",
                      "credit back-pressure", "x0 writes"};
        add_step(0, 0, addi(5'd1, 5'd0, 12'd5), 1, 5'd1, 64'd5);
        add_step(0, 1, lui(5'd2, 20'h12345), 1, 5'd2, 64'h0000_0000_1234_5000);
        add_step(0, 2, addi(5'd3, 5'd0, 12'hff9), 1, 5'd3, 64'hffff_ffff_ffff_fff9);
        add_step(0, 3, nop, 0, 5'd0, 64'd0);
        add_step(0, 4, nop, 0, 5'd0, 64'd0);
        add_step(0, 5, alu_rr(7'h00, 3'b000, 5'd4, 5'd1, 5'd3), 1, 5'd4, 64'hffff_ffff_ffff_fffe);
        add_step(0, 6, alu_rr(7'h00, 3'b110, 5'd5, 5'd2, 5'd1), 1, 5'd5, 64'h0000_0000_1234_5005);
        add_step(0, 7, alu_rr(7'h00, 3'b100, 5'd6, 5'd3, 5'd2), 1, 5'd6, 64'hffff_ffff_edcb_aff9);

        add_step(1, 0, addi(5'd1, 5'd0, 12'd3), 1, 5'd1, 64'd3);
        add_step(1, 1, addi(5'd2, 5'd1, 12'd4), 1, 5'd2, 64'd7);
        add_step(1, 2, alu_rr(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 1, 5'd3, 64'd10);
        add_step(1, 3, alu_rr(7'h20, 3'b000, 5'd4, 5'd3, 5'd1), 1, 5'd4, 64'd7);
        add_step(1, 4, alu_rr(7'h00, 3'b110, 5'd5, 5'd4, 5'd3), 1, 5'd5, 64'd15);
        add_step(1, 5, addi(5'd1, 5'd1, 12'd1), 1, 5'd1, 64'd4);
        add_step(1, 6, addi(5'd1, 5'd1, 12'd10), 1, 5'd1, 64'd14);
        add_step(1, 7, alu_rr(7'h00, 3'b000, 5'd6, 5'd1, 5'd5), 1, 5'd6, 64'd29); // x1 from EX/MEM

        add_step(2, 0, addi(5'd1, 5'd0, 12'd64), 1, 5'd1, 64'd64);
        add_step(2, 1, lui(5'd2, 20'habcde), 1, 5'd2, 64'hffff_ffff_abcd_e000);
        add_step(2, 2, addi(5'd2, 5'd2, 12'h123), 1, 5'd2, 64'hffff_ffff_abcd_e123);
        add_step(2, 3, sd(5'd2, 5'd1, 12'd8), 0, 5'd0, 64'd0);
        add_step(2, 4, ld(5'd3, 5'd1, 12'd8), 1, 5'd3, 64'hffff_ffff_abcd_e123);
        add_step(2, 5, alu_rr(7'h00, 3'b000, 5'd4, 5'd3, 5'd1), 1, 5'd4, 64'hffff_ffff_abcd_e163);
        add_step(2, 6, alu_rr(7'h00, 3'b100, 5'd5, 5'd4, 5'd3), 1, 5'd5, 64'h40);
        add_step(2, 7, nop, 0, 5'd0, 64'd0);

        add_step(3, 0, addi(5'd1, 5'd0, 12'd1), 1, 5'd1, 64'd1);
        add_step(3, 1, branch(3'b000, 5'd1, 5'd1, 13'd8), 0, 5'd0, 64'd0);  // taken to 12
        prog_tab[3][2] = addi(5'd2, 5'd0, 12'd99);
        add_step(3, 3, branch(3'b001, 5'd1, 5'd1, 13'd8), 0, 5'd0, 64'd0);
        add_step(3, 4, jal(5'd5, 21'd12), 1, 5'd5, 64'd20);
        prog_tab[3][5] = addi(5'd3, 5'd0, 12'd77);
        prog_tab[3][6] = addi(5'd4, 5'd0, 12'd88);
        add_step(3, 7, addi(5'd6, 5'd5, 12'd2), 1, 5'd6, 64'd22);

        // same program and stream as the first test
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog_tab[4][i] = prog_tab[0][i];
            exp_tab[4][i]  = exp_tab[0][i];
        end
        exp_cnt[4] = exp_cnt[0];

        add_step(5, 0, addi(5'd0, 5'd0, 12'd42), 0, 5'd0, 64'd0);
        add_step(5, 1, lui(5'd0, 20'h00001), 0, 5'd0, 64'd0);
        add_step(5, 2, addi(5'd7, 5'd0, 12'd5), 1, 5'd7, 64'd5);
        add_step(5, 3, alu_rr(7'h00, 3'b000, 5'd8, 5'd0, 5'd7), 1, 5'd8, 64'd5);
        add_step(5, 4, alu_rr(7'h00, 3'b110, 5'd9, 5'd0, 5'd0), 1, 5'd9, 64'd0);
    endtask

    task automatic check_retire(input core_pkg::retire_t got, input core_pkg::retire_t exp);
        checks++;
        if (got.pc !== exp.pc || got.instr !== exp.instr || got.reg_we !== exp.reg_we ||
            (exp.reg_we && (got.rd !== exp.rd || got.wdata !== exp.wdata))) begin
            errors++;
            $display("Error at %0t ns: retire pc %h instr %h rd %0d we %b wdata %h", $time,
                     got.pc, got.instr, got.rd, got.reg_we, got.wdata);
            $display("  expected pc %h instr %h rd %0d we %b wdata %h",
                     exp.pc, exp.instr, exp.rd, exp.reg_we, exp.wdata);
        end
    endtask

    task automatic check_credits(input int outstanding);
        checks++;
        if (outstanding > RETIRE_CREDITS || outstanding < 0) begin
            errors++;
            $display("Error at %0t ns: %0d records outstanding, limit %0d", $time,
                     outstanding, RETIRE_CREDITS);
        end
    endtask

    // program is written while reset is high, one word per cycle
    task automatic load_program(input int t);
        @(negedge clk);
        reset         = 1'b1;
        retire_credit = 1'b0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog_we   = 1'b1;
            prog_addr = i;
            prog_data = prog_tab[t][i];
            @(negedge clk);
        end
        prog_we = 1'b0;
        reset   = 1'b0;
    endtask

    task automatic collect_records(input int t, input bit random_credits);
        int got, cycle, outstanding, delay, idx;
        int due [$];   // cycle at which each credit goes back
        got         = 0;
        cycle       = 0;
        outstanding = 0;
        while (got < exp_cnt[t] && !timed_out) begin
            @(negedge clk);
            cycle++;
            idx = -1;
            foreach (due[k]) begin
                if (idx < 0 && due[k] <= cycle) idx = k;
            end
            retire_credit = (idx >= 0);   // one credit per cycle at most
            if (idx >= 0) begin
                due.delete(idx);
                outstanding--;
            end
            if (retire_valid) begin
                check_retire(retire, exp_tab[t][got]);
                got++;
                outstanding++;
                check_credits(outstanding);
                delay = random_credits ? 1 + int'($unsigned($random(seed)) % 12) : 1;
                due.push_back(cycle + delay);
            end
            if (cycle >= WAIT_LIMIT && got < exp_cnt[t]) begin
                $display("timeout: test %0d waited %0d cycles and saw only %0d of %0d records",
                         t + 1, cycle, got, exp_cnt[t]);
                errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin
        reset         = 1'b1;
        prog_we       = 1'b0;
        prog_addr     = '0;
        prog_data     = '0;
        retire_credit = 1'b0;
        errors        = 0;
        checks        = 0;
        failed_tests  = 0;
        tests_run     = 0;
        timed_out     = 1'b0;
        seed          = 32'h5188;
        fill_tables();
        for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
            err_before = errors;
            load_program(t);
            collect_records(t, t == 4);
            tests_run++;
            if (errors == err_before) begin
                $display("test %0d, %s: ok, %0d records", t + 1, test_name[t], exp_cnt[t]);
            end else begin
                failed_tests++;
                $display("test %0d, %s: %0d errors", t + 1, test_name[t], errors - err_before);
            end
        end
        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* pipeline_core.sv */
`timescale 1ns/1ns
module pipeline_core #(
    parameter int          IMEM_WORDS     = 64,
    parameter int          DMEM_WORDS     = 32,
    parameter int          RETIRE_CREDITS = 4,
    parameter logic [63:0] RESET_PC       = 64'd0
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              prog_we,
    input  logic [31:0]       prog_addr,
    input  logic [31:0]       prog_data,
    output core_pkg::retire_t retire,
    output logic              retire_valid,
    input  logic              retire_credit
);

    logic [63:0] pc;
    logic [31:0] fetch_instr;

    // IF/ID
    logic [63:0] id_pc;
    logic [31:0] id_instr;
    logic        id_valid;

    logic [4:0]      dec_rs1, dec_rs2, dec_rd;
    logic [63:0]     dec_imm;
    core_pkg::ctrl_t dec_ctrl;
    logic [63:0]     rf_a, rf_b;

    // ID/EX
    core_pkg::ex_stage_t ex_q;
    logic [63:0]         ex_rs1_data, ex_rs2_data;

    core_pkg::mem_stage_t mem_q;    // EX/MEM
    core_pkg::retire_t    wb_q;     // MEM/WB
    logic                 wb_valid;

    core_pkg::fwd_sel_e fwd_a, fwd_b;
    logic        stall_front, bubble_ex, flush_front, freeze, retire_full;
    logic [63:0] op_a, op_b, alu_b, alu_result, ex_result, target;
    logic [63:0] dmem_rdata, mem_value;
    logic        taken, redirect;

    instr_mem #(.IMEM_WORDS(IMEM_WORDS)) u_instr_mem (
        .clk, .prog_we, .prog_addr, .prog_data,
        .fetch_addr (pc),
        .fetch_instr(fetch_instr)
    );

    decoder u_decoder (
        .instr(id_instr), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
        .imm(dec_imm), .ctrl(dec_ctrl)
    );

    regfile u_regfile (
        .clk, .reset,
        .raddr_a(dec_rs1), .raddr_b(dec_rs2),
        .rdata_a(rf_a), .rdata_b(rf_b),
        .we     (wb_valid && wb_q.reg_we && !freeze),
        .waddr  (wb_q.rd),
        .wdata  (wb_q.wdata)
    );

    hazard_unit u_hazard_unit (
        .clk, .reset,
        .ex_rs1(ex_q.rs1), .ex_rs2(ex_q.rs2), .ex_rd(ex_q.rd),
        .id_rs1(id_valid ? dec_rs1 : 5'd0),
        .id_rs2(id_valid ? dec_rs2 : 5'd0),
        .ex_is_load(ex_q.valid && ex_q.ctrl.mem_re),
        .mem_rd(mem_q.rd), .mem_reg_we(mem_q.valid && mem_q.ctrl.reg_we),
        .wb_rd(wb_q.rd), .wb_reg_we(wb_valid && wb_q.reg_we),
        .redirect, .retire_full,
        .fwd_a, .fwd_b, .stall_front, .bubble_ex, .flush_front, .freeze
    );

    // operand forwarding
    assign mem_value = mem_q.ctrl.mem_re ? dmem_rdata : mem_q.result;

    always_comb begin
        case (fwd_a)
            core_pkg::fwd_mem: op_a = mem_value;
            core_pkg::fwd_wb:  op_a = wb_q.wdata;
            default:           op_a = ex_rs1_data;
        endcase
        case (fwd_b)
            core_pkg::fwd_mem: op_b = mem_value;
            core_pkg::fwd_wb:  op_b = wb_q.wdata;
            default:           op_b = ex_rs2_data;
        endcase
    end

    assign alu_b = ex_q.ctrl.use_imm ? ex_q.imm : op_b;

    alu u_alu (.op(ex_q.ctrl.alu_op), .a(op_a), .b(alu_b), .result(alu_result), .taken);

    assign ex_result = ex_q.ctrl.is_jal ? ex_q.pc + 64'd4 : alu_result; // link value
    assign target    = ex_q.pc + ex_q.imm;
    assign redirect  = ex_q.valid && (ex_q.ctrl.is_jal || (ex_q.ctrl.is_branch && taken));

    data_mem #(.DMEM_WORDS(DMEM_WORDS)) u_data_mem (
        .clk,
        .addr (mem_q.result),
        .we   (mem_q.valid && mem_q.ctrl.mem_we && !freeze),
        .wdata(mem_q.store_data),
        .rdata(dmem_rdata)
    );

    retire_sender #(.RETIRE_CREDITS(RETIRE_CREDITS)) u_retire_sender (
        .clk, .reset,
        .push    (wb_valid && !freeze),
        .push_rec(wb_q),
        .full    (retire_full),
        .retire, .retire_valid, .retire_credit
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= RESET_PC;
            id_valid   <= 1'b0;
            ex_q.valid <= 1'b0;
            mem_q      <= '0;
            wb_valid   <= 1'b0;
        end else if (!freeze) begin
            if (redirect) pc <= target;
            else if (!stall_front) pc <= pc + 64'd4;

            if (flush_front) begin
                id_valid <= 1'b0;
            end else if (!stall_front) begin
                id_pc    <= pc;
                id_instr <= fetch_instr;
                id_valid <= 1'b1;
            end

            ex_q <= '{pc: id_pc, instr: id_instr, rs1: dec_rs1, rs2: dec_rs2, rd: dec_rd,
                      imm: dec_imm, ctrl: dec_ctrl, valid: id_valid && !bubble_ex};
            ex_rs1_data <= rf_a;
            ex_rs2_data <= rf_b;

            mem_q <= '{pc: ex_q.pc, instr: ex_q.instr, rd: ex_q.rd, result: ex_result,
                       store_data: op_b, ctrl: ex_q.ctrl, valid: ex_q.valid};

            wb_q <= '{pc: mem_q.pc, instr: mem_q.instr, rd: mem_q.rd,
                      reg_we: mem_q.ctrl.reg_we, wdata: mem_value};
            wb_valid <= mem_q.valid;
        end
    end

endmodule

/* retire_sender.sv */
`timescale 1ns/1ns
module retire_sender #(
    parameter int RETIRE_CREDITS = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                push,
    input  core_pkg::retire_t   push_rec,
    output logic                full,
    output core_pkg::retire_t   retire,
    output logic                retire_valid,
    input  logic                retire_credit
);

    localparam int CW = $clog2(RETIRE_CREDITS + 1);

    core_pkg::retire_t q [2];
    logic [1:0]    q_cnt;
    logic          rd_ptr, wr_ptr;
    logic [CW-1:0] credit_cnt;
    logic          empty, send, bypass, deq, enq;

    assign empty  = (q_cnt == 2'd0);
    assign full   = (q_cnt == 2'd2);
    assign send   = (!empty || push) && credit_cnt != '0;
    assign bypass = send && empty && push;   // straight through to the output
    assign deq    = send && !empty;
    assign enq    = push && !bypass;

    always_ff @(posedge clk) begin
        if (reset) begin
            q_cnt        <= 2'd0;
            rd_ptr       <= 1'b0;
            wr_ptr       <= 1'b0;
            credit_cnt   <= CW'(RETIRE_CREDITS);
            retire_valid <= 1'b0;
        end else begin
            q_cnt        <= q_cnt + 2'(enq) - 2'(deq);
            credit_cnt   <= credit_cnt - CW'(send) + CW'(retire_credit);
            retire_valid <= send;
            if (deq) rd_ptr <= !rd_ptr;
            if (enq) wr_ptr <= !wr_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (enq) q[wr_ptr] <= push_rec;
        if (send) retire <= empty ? push_rec : q[rd_ptr];
    end

    a_credit_max: assert property (@(posedge clk) disable iff (reset)
        credit_cnt <= CW'(RETIRE_CREDITS));
    a_credit_min: assert property (@(posedge clk) disable iff (reset)
        credit_cnt == '0 |=> credit_cnt <= CW'(1));

endmodule

/* hazard_unit.sv */
`timescale 1ns/1ns
module hazard_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic [4:0]          ex_rs1,
    input  logic [4:0]          ex_rs2,
    input  logic [4:0]          ex_rd,
    input  logic [4:0]          id_rs1,
    input  logic [4:0]          id_rs2,
    input  logic                ex_is_load,
    input  logic [4:0]          mem_rd,
    input  logic                mem_reg_we,
    input  logic [4:0]          wb_rd,
    input  logic                wb_reg_we,
    input  logic                redirect,
    input  logic                retire_full,
    output core_pkg::fwd_sel_e  fwd_a,
    output core_pkg::fwd_sel_e  fwd_b,
    output logic                stall_front,
    output logic                bubble_ex,
    output logic                flush_front,
    output logic                freeze
);

    logic load_use;

    // youngest producer wins
    function automatic core_pkg::fwd_sel_e pick(input logic [4:0] src,
                                                input logic [4:0] m_rd, input logic m_we,
                                                input logic [4:0] w_rd, input logic w_we);
        if (src != 5'd0 && m_we && m_rd == src) return core_pkg::fwd_mem;
        if (src != 5'd0 && w_we && w_rd == src) return core_pkg::fwd_wb;
        return core_pkg::fwd_rf;
    endfunction

    assign fwd_a = pick(ex_rs1, mem_rd, mem_reg_we, wb_rd, wb_reg_we);
    assign fwd_b = pick(ex_rs2, mem_rd, mem_reg_we, wb_rd, wb_reg_we);

    assign load_use = ex_is_load && ex_rd != 5'd0 && (id_rs1 == ex_rd || id_rs2 == ex_rd);

    assign freeze      = retire_full;   // back-pressure holds everything
    assign stall_front = load_use && !freeze;
    assign flush_front = redirect && !freeze;
    assign bubble_ex   = (load_use || redirect) && !freeze;

    // a load in EX never redirects, so both cannot fire
    a_stall_xor_flush: assert property (@(posedge clk) disable iff (reset)
        !freeze |-> !(stall_front && flush_front));

endmodule

/* data_mem.sv */
`timescale 1ns/1ns
module data_mem #(
    parameter int DMEM_WORDS = 32
) (
    input  logic        clk,
    input  logic [63:0] addr,
    input  logic        we,
    input  logic [63:0] wdata,
    output logic [63:0] rdata
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [63:0] mem [DMEM_WORDS];
    logic [AW-1:0] index;

    assign index = addr[AW+2:3];   // doubleword index
    assign rdata = mem[index];

    always_ff @(posedge clk) begin
        if (we) mem[index] <= wdata;
    end

    // only doubleword accesses exist, stores must be aligned
    a_aligned: assert property (@(posedge clk) we |-> addr[2:0] == 3'b000);

endmodule

/* alu.sv */
`timescale 1ns/1ns
module alu (
    input  rv_isa_pkg::alu_op_e op,
    input  logic [63:0]         a,
    input  logic [63:0]         b,
    output logic [63:0]         result,
    output logic                taken
);

    logic equal;

    assign equal = (a == b);

    always_comb begin
        taken = 1'b0;
        case (op)
            rv_isa_pkg::alu_add:    result = a + b;
            rv_isa_pkg::alu_sub:    result = a - b;
            rv_isa_pkg::alu_and:    result = a & b;
            rv_isa_pkg::alu_or:     result = a | b;
            rv_isa_pkg::alu_xor:    result = a ^ b;
            rv_isa_pkg::alu_pass_b: result = b;
            rv_isa_pkg::alu_eq: begin
                taken  = equal;
                result = {63'd0, equal};
            end
            rv_isa_pkg::alu_ne: begin
                taken  = !equal;
                result = {63'd0, !equal};
            end
            default:                result = a + b;
        endcase
    end

endmodule

/* regfile.sv */
`timescale 1ns/1ns
module regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  raddr_a,
    input  logic [4:0]  raddr_b,
    output logic [63:0] rdata_a,
    output logic [63:0] rdata_b,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [63:0] wdata
);

    logic [63:0] regs [32];

    always_ff @(posedge clk) begin
        if (we) regs[waddr] <= wdata;
    end

    // write-before-read bypass
    assign rdata_a = (raddr_a == 5'd0) ? 64'd0 :
                     (we && waddr == raddr_a) ? wdata : regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0) ? 64'd0 :
                     (we && waddr == raddr_b) ? wdata : regs[raddr_b];

    // decode must have cleared reg_we for rd == x0
    a_no_x0_write: assert property (@(posedge clk) disable iff (reset) we |-> waddr != 5'd0);

endmodule

/* decoder.sv */
`timescale 1ns/1ns
module decoder (
    input  logic [31:0]         instr,
    output logic [4:0]          rs1,
    output logic [4:0]          rs2,
    output logic [4:0]          rd,
    output logic [63:0]         imm,
    output core_pkg::ctrl_t     ctrl
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [63:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl = '0;          // unknown opcode decodes as a bubble
        ctrl.alu_op = rv_isa_pkg::alu_add;
        imm  = imm_i;
        rs1  = instr[19:15];
        rs2  = 5'd0;        // only set when really read, avoids false stalls
        case (opcode)
            rv_isa_pkg::opc_op: begin
                rs2 = instr[24:20];
                ctrl.reg_we = 1'b1;
                case (funct3)
                    rv_isa_pkg::f3_add_sub: ctrl.alu_op = (funct7 == rv_isa_pkg::f7_sub) ?
                                            rv_isa_pkg::alu_sub : rv_isa_pkg::alu_add;
                    rv_isa_pkg::f3_xor: ctrl.alu_op = rv_isa_pkg::alu_xor;
                    rv_isa_pkg::f3_or:  ctrl.alu_op = rv_isa_pkg::alu_or;
                    rv_isa_pkg::f3_and: ctrl.alu_op = rv_isa_pkg::alu_and;
                    default:            ctrl.reg_we = 1'b0;
                endcase
            end
            rv_isa_pkg::opc_op_imm: begin
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = (funct3 == rv_isa_pkg::f3_addi);
            end
            rv_isa_pkg::opc_lui: begin
                rs1 = 5'd0;
                imm = imm_u;
                ctrl.alu_op  = rv_isa_pkg::alu_pass_b;
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
            end
            rv_isa_pkg::opc_load: begin
                ctrl.use_imm = 1'b1;
                ctrl.mem_re  = (funct3 == rv_isa_pkg::f3_ld);
                ctrl.reg_we  = (funct3 == rv_isa_pkg::f3_ld);
            end
            rv_isa_pkg::opc_store: begin
                rs2 = instr[24:20];
                imm = imm_s;
                ctrl.use_imm = 1'b1;
                ctrl.mem_we  = (funct3 == rv_isa_pkg::f3_sd);
            end
            rv_isa_pkg::opc_branch: begin
                rs2 = instr[24:20];
                imm = imm_b;
                ctrl.is_branch = (funct3 == rv_isa_pkg::f3_beq) || (funct3 == rv_isa_pkg::f3_bne);
                ctrl.branch_ne = (funct3 == rv_isa_pkg::f3_bne);
                ctrl.alu_op = ctrl.branch_ne ? rv_isa_pkg::alu_ne : rv_isa_pkg::alu_eq;
            end
            rv_isa_pkg::opc_jal: begin
                rs1 = 5'd0;
                imm = imm_j;
                ctrl.is_jal = 1'b1;
                ctrl.reg_we = 1'b1;
            end
            default: rs1 = 5'd0;
        endcase
        if (rd == 5'd0) ctrl.reg_we = 1'b0; // x0 writes retire without a write
    end

endmodule

/* instr_mem.sv */
`timescale 1ns/1ns
module instr_mem #(
    parameter int IMEM_WORDS = 64
) (
    input  logic        clk,
    input  logic        prog_we,
    input  logic [31:0] prog_addr,   // word index
    input  logic [31:0] prog_data,
    input  logic [63:0] fetch_addr,  // byte address
    output logic [31:0] fetch_instr
);

    localparam int AW = $clog2(IMEM_WORDS);

    logic [31:0] mem [IMEM_WORDS];

    // unwritten words fetch as nop
    initial begin
        for (int i = 0; i < IMEM_WORDS; i++) begin
            mem[i] = rv_isa_pkg::nop_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr[AW-1:0]] <= prog_data;
        end
    end

    assign fetch_instr = mem[fetch_addr[AW+1:2]];

endmodule

/* core_pkg.sv */
package core_pkg;

    typedef struct packed {
        rv_isa_pkg::alu_op_e alu_op;
        logic                use_imm;   // operand b is the immediate
        logic                reg_we;
        logic                mem_re;
        logic                mem_we;
        logic                is_branch;
        logic                is_jal;
        logic                branch_ne;
    } ctrl_t;

    // ID/EX contents
    typedef struct packed {
        logic [63:0] pc;
        logic [31:0] instr;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [63:0] imm;
        ctrl_t       ctrl;
        logic        valid;
    } ex_stage_t;

    // EX/MEM contents
    typedef struct packed {
        logic [63:0] pc;
        logic [31:0] instr;
        logic [4:0]  rd;
        logic [63:0] result;     // alu result or link address
        logic [63:0] store_data;
        ctrl_t       ctrl;
        logic        valid;
    } mem_stage_t;

    typedef struct packed {
        logic [63:0] pc;
        logic [31:0] instr;
        logic [4:0]  rd;
        logic        reg_we;
        logic [63:0] wdata;
    } retire_t;

    typedef enum logic [1:0] {
        fwd_rf,
        fwd_mem,
        fwd_wb
    } fwd_sel_e;

endpackage

/* rv_isa_pkg.sv */
package rv_isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b, // lui
        alu_eq,
        alu_ne
    } alu_op_e;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_addi    = 3'b000;
    localparam logic [2:0] f3_ld      = 3'b011;
    localparam logic [2:0] f3_sd      = 3'b011;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    localparam logic [6:0] f7_base    = 7'b0000000;
    localparam logic [6:0] f7_sub     = 7'b0100000;

    localparam logic [31:0] nop_instr = 32'h0000_0013; // addi x0,x0,0

endpackage
